/* verilog/dcache_config.svh */
// cache geometry and burst RAM sizing macros
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// byte address width seen by the client
`define DC_ADDR_W 32

// width of one cached word, a multiple of 8
`define DC_WORD_W 32

// 2^3 = 8 words per line
`define DC_WORD_IX_W 3

// 2^1 = 2 lines, direct mapped
`define DC_LINE_IX_W 1

// one RAM beat holds two words
`define DC_BEAT_W 64

// beat address width, 256 beats of 8 bytes = 2 KB
`define DC_RAM_ADDR_W 8

`endif

/* verilog/dcache_pkg.sv */
// derived cache widths and the enums shared by the cache blocks
`default_nettype none

`include "dcache_config.svh"

package dcache_pkg;

  // bytes in a cached word
  localparam int WORD_BYTES = `DC_WORD_W / 8;
  // low address bits that select a byte inside a word
  localparam int ALIGN_W = $clog2(WORD_BYTES);

  localparam int WORDS_PER_LINE = 1 << `DC_WORD_IX_W;
  localparam int WORDS_PER_BEAT = `DC_BEAT_W / `DC_WORD_W;
  // a line moves as one burst of this many beats
  localparam int BEATS_PER_LINE = WORDS_PER_LINE / WORDS_PER_BEAT;
  localparam int LINE_W = WORDS_PER_LINE * `DC_WORD_W;

  // |tag|line|word|00| split of the byte address
  localparam int TAG_W = `DC_ADDR_W - `DC_LINE_IX_W - `DC_WORD_IX_W - ALIGN_W;

  // byte address to beat address
  localparam int BEAT_SHIFT = ALIGN_W + $clog2(WORDS_PER_BEAT);

  // client command, encoded as on the command pin
  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } cache_cmd_e;

  typedef enum logic [2:0] {
    S_IDLE,
    S_LOOKUP,
    S_WRITE_BACK,
    S_FILL,
    S_RESPOND
  } ctrl_state_e;

  // burst direction, encoded as on br_cmd
  typedef enum logic {
    BURST_READ  = 1'b0,
    BURST_WRITE = 1'b1
  } burst_op_e;

endpackage

`default_nettype wire

/* verilog/dcache_ifs.sv */
// cache_req_if: accepted request from the decoder to the controller
// line_burst_if: line transfer between the controller and the burst port
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

interface cache_req_if;
  import dcache_pkg::*;

  // one-cycle pulse per accepted request
  logic                      valid;
  cache_cmd_e                cmd;
  // address fields, held until the next acceptance
  logic [TAG_W-1:0]          tag;
  logic [`DC_LINE_IX_W-1:0]  line_ix;
  logic [`DC_WORD_IX_W-1:0]  word_ix;
  logic [WORD_BYTES-1:0]     byte_en;
  logic [`DC_WORD_W-1:0]     wdata;

  modport decode_mp(output valid, cmd, tag, line_ix, word_ix, byte_en, wdata);
  modport ctrl_mp(input valid, cmd, tag, line_ix, word_ix, byte_en, wdata);
endinterface

interface line_burst_if;
  import dcache_pkg::*;

  // start is a single-cycle pulse, only while the port is idle
  logic                       start;
  burst_op_e                  op;
  // beat address of the first beat in the line
  logic [`DC_RAM_ADDR_W-1:0]  ram_addr;
  // line to write, sampled with start
  logic [LINE_W-1:0]          wr_line;
  // pulses once at the end of every burst
  logic                       done;
  // gathered line, valid together with done on reads
  logic [LINE_W-1:0]          rd_line;

  modport ctrl_mp(output start, op, ram_addr, wr_line, input done, rd_line);
  modport port_mp(input start, op, ram_addr, wr_line, output done, rd_line);
endinterface

`default_nettype wire

/* verilog/dcache_request_decode.sv */
// client request capture and byte address field split
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_request_decode (
  input wire                               clk,
  input wire                               rst,
  input wire                               enable,
  input wire                               command,
  input wire [`DC_ADDR_W-1:0]              address,
  input wire [dcache_pkg::WORD_BYTES-1:0]  write_enable_bytes,
  input wire [`DC_WORD_W-1:0]              data_in,
  input wire                               busy,
  cache_req_if.decode_mp                   req
);
  import dcache_pkg::*;

  logic accept;

  // a request is only taken while the cache is idle
  assign accept = enable && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      req.valid <= 1'b0;
    end else begin
      req.valid <= accept;
    end
  end

  // request fields are held until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      req.cmd <= command ? CMD_WRITE : CMD_READ;
      // the two alignment bits are dropped
      req.word_ix <= address[ALIGN_W +: `DC_WORD_IX_W];
      req.line_ix <= address[ALIGN_W + `DC_WORD_IX_W +: `DC_LINE_IX_W];
      req.tag <= address[`DC_ADDR_W-1 -: TAG_W];
      req.byte_en <= write_enable_bytes;
      req.wdata <= data_in;
    end
  end

  // the controller must raise busy in time to block a second request
  a_valid_single: assert property (@(posedge clk) disable iff (rst)
    req.valid |=> !req.valid)
    else $error("request valid high on two cycles in a row");

endmodule

`default_nettype wire

/* verilog/dcache_line_store.sv */
// tag, valid, dirty and data arrays of the direct-mapped cache
// combinational lookup, whole-line fill and byte-merging word write
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_line_store (
  input  wire                               clk,
  input  wire                               rst,
  // lookup index
  input  wire [`DC_LINE_IX_W-1:0]           line_ix,
  input  wire [dcache_pkg::TAG_W-1:0]       tag,
  input  wire [`DC_WORD_IX_W-1:0]           word_ix,
  // lookup results
  output logic                              hit,
  output logic                              dirty,
  output logic [dcache_pkg::TAG_W-1:0]      victim_tag,
  output logic [dcache_pkg::LINE_W-1:0]     line_data,
  output logic [`DC_WORD_W-1:0]             word,
  // line fill from the RAM
  input  wire                               fill_en,
  input  wire [dcache_pkg::LINE_W-1:0]      fill_line,
  // client word write
  input  wire                               wr_en,
  input  wire [dcache_pkg::WORD_BYTES-1:0]  byte_en,
  input  wire [`DC_WORD_W-1:0]              wdata
);
  import dcache_pkg::*;

  localparam int LINES = 1 << `DC_LINE_IX_W;

  logic [LINES-1:0]   valid_q;
  logic [LINES-1:0]   dirty_q;
  logic [TAG_W-1:0]   tag_q [LINES];
  // word i of a line sits at bits [i*DC_WORD_W +: DC_WORD_W]
  logic [LINE_W-1:0]  data_q [LINES];
  logic [`DC_WORD_W-1:0] merged_word;

  // everything below is read straight from the indexed line
  assign line_data = data_q[line_ix];
  assign victim_tag = tag_q[line_ix];
  assign word = line_data[word_ix * `DC_WORD_W +: `DC_WORD_W];
  assign hit = valid_q[line_ix] && (tag_q[line_ix] == tag);
  assign dirty = dirty_q[line_ix];

  // enabled bytes from the client, the rest from the cached word
  always_comb begin
    merged_word = word;
    for (int b = 0; b < WORD_BYTES; b++) begin
      if (byte_en[b]) begin
        merged_word[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
  end

  // line state
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_en) begin
      // a freshly filled line matches the RAM
      valid_q[line_ix] <= 1'b1;
      dirty_q[line_ix] <= 1'b0;
    end else if (wr_en) begin
      dirty_q[line_ix] <= 1'b1;
    end
  end

  // tags and data
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[line_ix] <= tag;
      data_q[line_ix] <= fill_line;
    end else if (wr_en) begin
      data_q[line_ix][word_ix * `DC_WORD_W +: `DC_WORD_W] <= merged_word;
    end
  end

endmodule

`default_nettype wire

/* verilog/dcache_controller.sv */
// cache FSM: lookup, dirty write-back, line fill and response
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_controller (
  input  wire                                clk,
  input  wire                                rst,
  cache_req_if.ctrl_mp                       req,
  line_burst_if.ctrl_mp                      burst,
  // line store index and write controls
  output logic [`DC_LINE_IX_W-1:0]           line_ix,
  output logic [dcache_pkg::TAG_W-1:0]       tag,
  output logic [`DC_WORD_IX_W-1:0]           word_ix,
  output logic                               fill_en,
  output logic [dcache_pkg::LINE_W-1:0]      fill_line,
  output logic                               wr_en,
  output logic [dcache_pkg::WORD_BYTES-1:0]  byte_en,
  output logic [`DC_WORD_W-1:0]              wdata,
  // line store lookup results
  input  wire                                hit,
  input  wire                                dirty,
  input  wire [dcache_pkg::TAG_W-1:0]        victim_tag,
  input  wire [dcache_pkg::LINE_W-1:0]       line_data,
  input  wire [`DC_WORD_W-1:0]               word,
  // client response
  output logic [`DC_WORD_W-1:0]              data_out,
  output logic                               data_out_ready,
  output logic                               busy
);
  import dcache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        write_back;

  // beat address of the first beat of a line
  function automatic logic [`DC_RAM_ADDR_W-1:0] line_beat_addr(
    input logic [TAG_W-1:0]         line_tag,
    input logic [`DC_LINE_IX_W-1:0] ix
  );
    logic [`DC_ADDR_W-1:0] byte_addr;
    byte_addr = {line_tag, ix, {(`DC_WORD_IX_W + ALIGN_W){1'b0}}};
    return `DC_RAM_ADDR_W'(byte_addr >> BEAT_SHIFT);
  endfunction

  // the store is always indexed by the request in flight
  assign line_ix = req.line_ix;
  assign tag = req.tag;
  assign word_ix = req.word_ix;
  assign byte_en = req.byte_en;
  assign wdata = req.wdata;

  // dirty victim must go out before the new line comes in
  assign write_back = (state_q == S_LOOKUP) && !hit && dirty;

  // first burst starts from lookup and the fill follows a finished write-back
  assign burst.start = ((state_q == S_LOOKUP) && !hit) ||
                       ((state_q == S_WRITE_BACK) && burst.done);
  assign burst.op = write_back ? BURST_WRITE : BURST_READ;
  assign burst.ram_addr = write_back ? line_beat_addr(victim_tag, req.line_ix)
                                     : line_beat_addr(req.tag, req.line_ix);
  assign burst.wr_line = line_data;

  // store the gathered line on the last read beat
  assign fill_en = (state_q == S_FILL) && burst.done;
  assign fill_line = burst.rd_line;

  // the write merges into a hit line or a freshly filled one
  assign wr_en = (state_q == S_RESPOND) && (req.cmd == CMD_WRITE);

  // response goes out in the cycle busy drops
  assign data_out = word;
  assign data_out_ready = (state_q == S_RESPOND) && (req.cmd == CMD_READ);
  // the valid cycle covers the gap before lookup
  assign busy = req.valid || (state_q == S_LOOKUP) ||
                (state_q == S_WRITE_BACK) || (state_q == S_FILL);

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (req.valid) begin
          state_d = S_LOOKUP;
        end
      end
      S_LOOKUP: begin
        if (hit) begin
          state_d = S_RESPOND;
        end else if (dirty) begin
          state_d = S_WRITE_BACK;
        end else begin
          state_d = S_FILL;
        end
      end
      S_WRITE_BACK: begin
        if (burst.done) begin
          state_d = S_FILL;
        end
      end
      S_FILL: begin
        if (burst.done) begin
          state_d = S_RESPOND;
        end
      end
      S_RESPOND: state_d = S_IDLE;
      default: state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // the port only ends a burst that a write-back or a fill is waiting on
  a_done_in_burst: assert property (@(posedge clk) disable iff (rst)
    burst.done |-> (state_q == S_WRITE_BACK) || (state_q == S_FILL))
    else $error("burst done outside write-back or fill");

endmodule

`default_nettype wire

/* verilog/dcache_burst_port.sv */
// burst RAM port: command hold under br_busy, write beat serializer
// and read beat gatherer
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_burst_port (
  input  wire                          clk,
  input  wire                          rst,
  line_burst_if.port_mp                burst,
  output logic                         br_cmd,
  output logic                         br_cmd_en,
  output logic [`DC_RAM_ADDR_W-1:0]    br_addr,
  output logic [`DC_BEAT_W-1:0]        br_wr_data,
  input  wire  [`DC_BEAT_W-1:0]        br_rd_data,
  input  wire                          br_rd_data_valid,
  input  wire                          br_busy
);
  import dcache_pkg::*;

  localparam int CNT_W = $clog2(BEATS_PER_LINE);

  // command waiting for br_busy to drop
  logic                       pend_q;
  // command issued, beats still moving
  logic                       active_q;
  logic [CNT_W-1:0]           cnt_q;
  burst_op_e                  op_q;
  logic [`DC_RAM_ADDR_W-1:0]  addr_q;
  // write: low beat goes out next; read: beats enter from the top
  logic [LINE_W-1:0]          line_q;
  logic [LINE_W-1:0]          line_next;
  logic                       beat_fire;

  assign br_cmd_en = pend_q && !br_busy;
  assign br_cmd = (op_q == BURST_WRITE);
  assign br_addr = addr_q;
  // first write beat goes out with the command
  assign br_wr_data = line_q[`DC_BEAT_W-1:0];

  // one beat moves in this cycle
  assign beat_fire = (op_q == BURST_WRITE) ? (br_cmd_en || active_q)
                                           : (active_q && br_rd_data_valid);

  // shift toward bit 0, a read beat lands on top
  assign line_next = {br_rd_data, line_q[LINE_W-1:`DC_BEAT_W]};

  // last beat ends the burst
  assign burst.done = active_q && beat_fire && (cnt_q == CNT_W'(BEATS_PER_LINE - 1));
  assign burst.rd_line = line_next;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_q <= 1'b0;
      active_q <= 1'b0;
      cnt_q <= '0;
    end else begin
      if (burst.start) begin
        pend_q <= 1'b1;
      end else if (br_cmd_en) begin
        pend_q <= 1'b0;
      end
      if (burst.done) begin
        active_q <= 1'b0;
      end else if (br_cmd_en) begin
        active_q <= 1'b1;
      end
      if (burst.start || burst.done) begin
        cnt_q <= '0;
      end else if (beat_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  // burst payload
  always_ff @(posedge clk) begin
    if (burst.start) begin
      op_q <= burst.op;
      addr_q <= burst.ram_addr;
      line_q <= burst.wr_line;
    end else if (beat_fire) begin
      line_q <= line_next;
    end
  end

  // the RAM returns read beats only for read commands
  a_no_rd_in_write: assert property (@(posedge clk) disable iff (rst)
    (active_q && (op_q == BURST_WRITE)) |-> !br_rd_data_valid)
    else $error("read beat during a write burst");

endmodule

`default_nettype wire

/* verilog/dcache_top.sv */
// write-back data cache top level, client and burst RAM pins
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_top (
  input  wire                               clk,
  input  wire                               rst,
  // client
  input  wire                               enable,
  input  wire                               command,
  input  wire [`DC_ADDR_W-1:0]              address,
  input  wire [dcache_pkg::WORD_BYTES-1:0]  write_enable_bytes,
  input  wire [`DC_WORD_W-1:0]              data_in,
  output logic [`DC_WORD_W-1:0]             data_out,
  output logic                              data_out_ready,
  output logic                              busy,
  // burst RAM
  output logic                              br_cmd,
  output logic                              br_cmd_en,
  output logic [`DC_RAM_ADDR_W-1:0]         br_addr,
  output logic [`DC_BEAT_W-1:0]             br_wr_data,
  input  wire  [`DC_BEAT_W-1:0]             br_rd_data,
  input  wire                               br_rd_data_valid,
  input  wire                               br_busy
);
  import dcache_pkg::*;

  cache_req_if  u_req_if ();
  line_burst_if u_burst_if ();

  // controller to line store
  logic [`DC_LINE_IX_W-1:0]  st_line_ix;
  logic [TAG_W-1:0]          st_tag;
  logic [`DC_WORD_IX_W-1:0]  st_word_ix;
  logic                      st_fill_en;
  logic [LINE_W-1:0]         st_fill_line;
  logic                      st_wr_en;
  logic [WORD_BYTES-1:0]     st_byte_en;
  logic [`DC_WORD_W-1:0]     st_wdata;
  // line store to controller
  logic                      st_hit;
  logic                      st_dirty;
  logic [TAG_W-1:0]          st_victim_tag;
  logic [LINE_W-1:0]         st_line_data;
  logic [`DC_WORD_W-1:0]     st_word;

  dcache_request_decode u_decode (
    .clk, .rst, .enable, .command, .address, .write_enable_bytes, .data_in,
    .busy, .req(u_req_if.decode_mp)
  );

  dcache_controller u_ctrl (
    .clk, .rst, .req(u_req_if.ctrl_mp), .burst(u_burst_if.ctrl_mp),
    .line_ix(st_line_ix), .tag(st_tag), .word_ix(st_word_ix),
    .fill_en(st_fill_en), .fill_line(st_fill_line), .wr_en(st_wr_en),
    .byte_en(st_byte_en), .wdata(st_wdata), .hit(st_hit), .dirty(st_dirty),
    .victim_tag(st_victim_tag), .line_data(st_line_data), .word(st_word),
    .data_out, .data_out_ready, .busy
  );

  dcache_line_store u_store (
    .clk, .rst, .line_ix(st_line_ix), .tag(st_tag), .word_ix(st_word_ix),
    .hit(st_hit), .dirty(st_dirty), .victim_tag(st_victim_tag),
    .line_data(st_line_data), .word(st_word), .fill_en(st_fill_en),
    .fill_line(st_fill_line), .wr_en(st_wr_en), .byte_en(st_byte_en),
    .wdata(st_wdata)
  );

  dcache_burst_port u_port (
    .clk, .rst, .burst(u_burst_if.port_mp), .br_cmd, .br_cmd_en, .br_addr,
    .br_wr_data, .br_rd_data, .br_rd_data_valid, .br_busy
  );

endmodule

`default_nettype wire

/* verification/burst_ram_model.sv */
// behavioral burst RAM: four-beat bursts, fixed read latency,
// br_busy raised for a few cycles after every few commands
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module burst_ram_model #(
  parameter int READ_LATENCY = 3,
  parameter int BUSY_EVERY = 3,
  parameter int BUSY_CYCLES = 4
) (
  input  wire                        clk,
  input  wire                        rst,
  input  wire                        br_cmd,
  input  wire                        br_cmd_en,
  input  wire  [`DC_RAM_ADDR_W-1:0]  br_addr,
  input  wire  [`DC_BEAT_W-1:0]      br_wr_data,
  output logic [`DC_BEAT_W-1:0]      br_rd_data,
  output logic                       br_rd_data_valid,
  output logic                       br_busy
);

  logic [`DC_BEAT_W-1:0]      mem [1 << `DC_RAM_ADDR_W];
  logic [`DC_RAM_ADDR_W-1:0]  wr_addr;
  logic [`DC_RAM_ADDR_W-1:0]  rd_addr;
  int                         wr_left;
  int                         rd_left;
  int                         rd_wait;
  int                         busy_left;
  int                         cmds;
  // next read beat, put on the pins at the falling edge
  logic                       beat_valid;
  logic [`DC_BEAT_W-1:0]      beat_data;

  // word content derived from its byte address
  function automatic logic [31:0] fill_word(input logic [31:0] byte_addr);
    return {byte_addr[15:0] ^ 16'h5a5a, ~byte_addr[15:0]};
  endfunction

  initial begin
    br_rd_data = '0;
    br_rd_data_valid = 1'b0;
    br_busy = 1'b0;
    // lower word of a beat sits in the low half
    for (int b = 0; b < (1 << `DC_RAM_ADDR_W); b++) begin
      mem[b] = {fill_word(b * 8 + 4), fill_word(b * 8)};
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      wr_left <= 0;
      rd_left <= 0;
      rd_wait <= 0;
      busy_left <= 0;
      cmds <= 0;
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= 1'b0;
      if (busy_left > 0) begin
        busy_left <= busy_left - 1;
      end
      // write beats after the one that came with the command
      if (wr_left > 0) begin
        mem[wr_addr] <= br_wr_data;
        wr_addr <= wr_addr + 1'b1;
        wr_left <= wr_left - 1;
      end
      if (rd_left > 0) begin
        if (rd_wait > 0) begin
          rd_wait <= rd_wait - 1;
        end else begin
          beat_valid <= 1'b1;
          beat_data <= mem[rd_addr];
          rd_addr <= rd_addr + 1'b1;
          rd_left <= rd_left - 1;
          // every other read gets a gap after its second beat
          rd_wait <= (rd_left == 3 && cmds[0]) ? 1 : 0;
        end
      end
      if (br_cmd_en) begin
        cmds <= cmds + 1;
        if ((cmds + 1) % BUSY_EVERY == 0) begin
          busy_left <= BUSY_CYCLES;
        end
        if (br_cmd) begin
          mem[br_addr] <= br_wr_data;
          wr_addr <= br_addr + 1'b1;
          wr_left <= 3;
        end else begin
          rd_addr <= br_addr;
          rd_left <= 4;
          rd_wait <= READ_LATENCY;
        end
      end
    end
  end

  // outputs change on the falling edge
  always @(negedge clk) begin
    br_rd_data_valid <= beat_valid && !rst;
    br_rd_data <= beat_data;
    br_busy <= (busy_left > 0);
  end

endmodule

`default_nettype wire

/* verification/dcache_tb.sv */
// data cache testbench: clock, reset, directed and random requests,
// shadow memory reference, data_out compare and final report
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module dcache_tb;

  localparam int WORDS = 512;
  localparam int TIMEOUT = 400;

  logic                        clk;
  logic                        rst;
  logic                        enable;
  logic                        command;
  logic [`DC_ADDR_W-1:0]       address;
  logic [3:0]                  write_enable_bytes;
  logic [`DC_WORD_W-1:0]       data_in;
  wire  [`DC_WORD_W-1:0]       data_out;
  wire                         data_out_ready;
  wire                         busy;
  wire                         br_cmd;
  wire                         br_cmd_en;
  wire  [`DC_RAM_ADDR_W-1:0]   br_addr;
  wire  [`DC_BEAT_W-1:0]       br_wr_data;
  wire  [`DC_BEAT_W-1:0]       br_rd_data;
  wire                         br_rd_data_valid;
  wire                         br_busy;

  // word-indexed copy of what the RAM plus cache should hold
  logic [31:0]  shadow [WORDS];
  logic [31:0]  lcg_state;
  logic [31:0]  cur_addr;
  // {br_cmd, br_addr} of every command the RAM took
  logic [8:0]   cmd_log [$];
  int           errors;
  int           tests;
  int           failed_tests;
  int           test_err_mark;
  int           ready_count;
  int           busy_cycles;
  bit           timed_out;

  dcache_top u_dut (
    .clk, .rst, .enable, .command, .address, .write_enable_bytes, .data_in,
    .data_out, .data_out_ready, .busy, .br_cmd, .br_cmd_en, .br_addr,
    .br_wr_data, .br_rd_data, .br_rd_data_valid, .br_busy
  );

  burst_ram_model u_ram (
    .clk, .rst, .br_cmd, .br_cmd_en, .br_addr, .br_wr_data, .br_rd_data,
    .br_rd_data_valid, .br_busy
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] preload_word(input logic [31:0] byte_addr);
    return {byte_addr[15:0] ^ 16'h5a5a, ~byte_addr[15:0]};
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] byte_addr);
    return shadow[byte_addr[10:2]];
  endfunction

  // enabled bytes come from the new data
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0] mask);
    logic [31:0] res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) res[b*8 +: 8] = new_word[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // one client request, waits for busy to fall
  task automatic run_request(input logic cmd, input logic [31:0] addr,
                             input logic [3:0] mask, input logic [31:0] data);
    int n;
    int ready_before;
    if (timed_out) return;
    @(negedge clk);
    enable = 1'b1;
    command = cmd;
    address = addr;
    write_enable_bytes = mask;
    data_in = data;
    cur_addr = addr;
    ready_before = ready_count;
    @(negedge clk);
    enable = 1'b0;
    if (!busy) begin
      errors++;
      $display("request at address %h was not accepted", addr);
    end
    n = 0;
    busy_cycles = 0;
    while (busy && n < TIMEOUT) begin
      busy_cycles++;
      n++;
      @(negedge clk);
    end
    if (busy) begin
      timed_out = 1'b1;
      errors++;
      $display("timeout: busy still high %0d cycles after request to %h", TIMEOUT, addr);
      return;
    end
    if (cmd) shadow[addr[10:2]] = merge_bytes(shadow[addr[10:2]], data, mask);
    // let the compare process count the response first
    @(posedge clk);
    check_value("data_out_ready count", ready_before + (cmd ? 0 : 1), ready_count);
  endtask

  task automatic start_test();
    tests++;
    test_err_mark = errors;
  endtask

  task automatic finish_test(input string name);
    if (errors == test_err_mark) begin
      $display("test %0d %s: ok", tests, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", tests, name, errors - test_err_mark);
    end
  endtask

  // every read response against the shadow memory
  always @(negedge clk) begin
    if (!rst && data_out_ready) begin
      ready_count++;
      check_value("data_out", expected_word(cur_addr), data_out);
      if (busy) begin
        errors++;
        $display("data_out_ready and busy high together at %0t", $time);
      end
    end
  end

  // commands as the RAM takes them on the rising edge
  always @(posedge clk) begin
    if (!rst && br_cmd_en) cmd_log.push_back({br_cmd, br_addr});
  end

  initial begin
    logic [31:0] r;
    logic [31:0] rdata;
    logic [31:0] raddr;
    logic [3:0]  rmask;
    logic        rcmd;
    int          mark;
    clk = 1'b0;
    rst = 1'b1;
    enable = 1'b0;
    command = 1'b0;
    address = '0;
    write_enable_bytes = '0;
    data_in = '0;
    cur_addr = '0;
    lcg_state = 32'd28806;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    ready_count = 0;
    timed_out = 1'b0;
    for (int w = 0; w < WORDS; w++) shadow[w] = preload_word(w * 4);
    repeat (4) @(negedge clk);
    rst = 1'b0;

    start_test();
    @(negedge clk);
    check_value("busy", 0, busy);
    check_value("data_out_ready", 0, data_out_ready);
    check_value("br_cmd_en", 0, br_cmd_en);
    finish_test("reset state");

    // line 0, tag 1: clean miss, then a hit in the same line
    start_test();
    mark = cmd_log.size();
    run_request(1'b0, 32'h040, 4'h0, '0);
    check_value("br_cmd_en count", mark + 1, cmd_log.size());
    if (cmd_log.size() > mark) begin
      check_value("br_cmd", 0, cmd_log[mark][8]);
      check_value("br_addr", 8'h08, cmd_log[mark][7:0]);
    end
    mark = cmd_log.size();
    run_request(1'b0, 32'h04c, 4'h0, '0);
    check_value("br_cmd_en count", mark, cmd_log.size());
    check_value("busy cycles", 2, busy_cycles);
    finish_test("read miss then read hit");

    start_test();
    mark = cmd_log.size();
    run_request(1'b1, 32'h048, 4'b0101, 32'hdead_beef);
    check_value("busy cycles", 2, busy_cycles);
    check_value("br_cmd_en count", mark, cmd_log.size());
    run_request(1'b0, 32'h048, 4'h0, '0);
    finish_test("byte-enabled write hit");

    // tag 0x11 on line 0 evicts the dirty tag 1 line
    start_test();
    mark = cmd_log.size();
    run_request(1'b0, 32'h440, 4'h0, '0);
    check_value("br_cmd_en count", mark + 2, cmd_log.size());
    if (cmd_log.size() > mark + 1) begin
      check_value("br_cmd", 1, cmd_log[mark][8]);
      check_value("br_addr", 8'h08, cmd_log[mark][7:0]);
      check_value("br_cmd", 0, cmd_log[mark+1][8]);
      check_value("br_addr", 8'h88, cmd_log[mark+1][7:0]);
    end
    run_request(1'b0, 32'h048, 4'h0, '0);
    finish_test("dirty eviction");

    // line 1 is still invalid
    start_test();
    mark = cmd_log.size();
    run_request(1'b1, 32'h0a4, 4'b1100, 32'h1234_5678);
    check_value("br_cmd_en count", mark + 1, cmd_log.size());
    if (cmd_log.size() > mark) begin
      check_value("br_cmd", 0, cmd_log[mark][8]);
      check_value("br_addr", 8'h14, cmd_log[mark][7:0]);
    end
    run_request(1'b0, 32'h0a4, 4'h0, '0);
    finish_test("write miss");

    start_test();
    for (int i = 0; i < 200; i++) begin
      r = lcg_next();
      rcmd = r[20];
      raddr = {21'd0, r[18:10], 2'b00};
      rmask = r[27:24];
      rdata = lcg_next();
      run_request(rcmd, raddr, rmask, rdata);
    end
    finish_test("random traffic");

    $display("%0d tests run, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_ifs.sv
verilog/dcache_request_decode.sv
verilog/dcache_line_store.sv
verilog/dcache_controller.sv
verilog/dcache_burst_port.sv
verilog/dcache_top.sv
verification/burst_ram_model.sv
verification/dcache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module dcache_tb -f vlog.f -o dcache_sim

./obj_dir/dcache_sim | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
